//--- logic/softermax_fmt_pkg.sv
// Fixed-point number formats shared by the softermax datapath, imported by each datapath module
package softermax_fmt_pkg;

  // Input score, signed Q4.4
  typedef logic signed [7:0] score_t;
  localparam int SCORE_FRAC = 4;

  // Signed integer part of a score, holds the running maximum
  typedef logic signed [3:0] exp_int_t;

  typedef logic [9:0]  pow2_t;  // Unsigned Q2.8 power of two
  typedef logic [15:0] sum_t;   // Unsigned Q8.8 running sum

  // Normalized output, unsigned Q1.7
  typedef logic [7:0] prob_t;
  localparam int PROB_FRAC = 7;

endpackage

//--- logic/softermax_ctrl_pkg.sv
// Vector length limits, index types and controller states, imported by the control and buffer
package softermax_ctrl_pkg;

  localparam int MAX_DEPTH = 16;

  // Depth port must hold MAX_DEPTH itself
  typedef logic [$clog2(MAX_DEPTH):0] depth_t;

  // Score buffer address
  typedef logic [$clog2(MAX_DEPTH)-1:0] idx_t;

  typedef enum logic [2:0] {
    IDLE,    // Waiting for the first score of a vector
    FILL,    // Accepting the remaining scores
    DRAIN,   // Read address presented to the buffer
    DIVIDE,  // Divider running on one element
    HOLD     // Result offered on the output stream
  } ctrl_state_t;

endpackage

//--- logic/softermax_pow2.sv
// Combinational base-2 power of a non-positive fixed-point difference by table lookup and shift
`timescale 1ns/1ns
module softermax_pow2
  import softermax_fmt_pkg::*;
(
  input  logic signed [8:0] diff,
  output pow2_t             pow
);

  pow2_t      frac_pow;
  logic [4:0] shamt;

  // Minus the floor of diff over 16
  assign shamt = 5'd0 - diff[8:4];

  always_comb begin
    unique case (diff[3:0])  // round(256 * 2^(f/16))
      4'd0:  frac_pow = 10'd256;
      4'd1:  frac_pow = 10'd267;
      4'd2:  frac_pow = 10'd279;
      4'd3:  frac_pow = 10'd292;
      4'd4:  frac_pow = 10'd304;
      4'd5:  frac_pow = 10'd318;
      4'd6:  frac_pow = 10'd332;
      4'd7:  frac_pow = 10'd347;
      4'd8:  frac_pow = 10'd362;
      4'd9:  frac_pow = 10'd378;
      4'd10: frac_pow = 10'd395;
      4'd11: frac_pow = 10'd412;
      4'd12: frac_pow = 10'd431;
      4'd13: frac_pow = 10'd450;
      4'd14: frac_pow = 10'd470;
      default: frac_pow = 10'd490;
    endcase
  end

  assign pow = frac_pow >> shamt;  // Large shifts underflow to zero

endmodule

//--- logic/softermax_window.sv
// Running integer maximum and power-of-two sum over the fill pass, rescaled by shift on a new max
`timescale 1ns/1ns
module softermax_window
  import softermax_fmt_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  logic     clear,
  input  logic     update,
  input  score_t   score,
  output exp_int_t max_int,
  output sum_t     sum
);

  exp_int_t          int_part;
  exp_int_t          new_max;
  logic [3:0]        rise;
  logic signed [8:0] term_diff;
  pow2_t             term_pow;

  assign int_part  = exp_int_t'(score >>> SCORE_FRAC);  // Floor of the score
  assign new_max   = (clear || int_part > max_int) ? int_part : max_int;
  assign rise      = int_part - max_int;  // Only used when the max grows
  assign term_diff = 9'(score) - (9'(new_max) <<< SCORE_FRAC);

  softermax_pow2 u_term_pow2 (
    .diff (term_diff),
    .pow  (term_pow)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      max_int <= '0;
      sum     <= '0;
    end else if (update) begin
      if (clear) begin
        sum <= sum_t'(term_pow);  // Drop the previous vector
      end else if (int_part > max_int) begin
        // Old terms were taken against a smaller max
        sum <= (sum >> rise) + sum_t'(term_pow);
      end else begin
        sum <= sum + sum_t'(term_pow);
      end
      max_int <= new_max;
    end
  end

endmodule

//--- logic/softermax_buffer.sv
// Score store written during the fill pass and read back with one cycle latency in the drain
`timescale 1ns/1ns
module softermax_buffer
  import softermax_fmt_pkg::*;
  import softermax_ctrl_pkg::*;
(
  input  logic   clk,
  input  logic   we,
  input  idx_t   waddr,
  input  score_t wdata,
  input  idx_t   raddr,
  output score_t rdata
);

  score_t mem [MAX_DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr];  // Registered read port
  end

endmodule

//--- logic/softermax_norm.sv
// Restoring divider giving floor(pow * 128 / sum), one quotient bit per cycle after a load
`timescale 1ns/1ns
module softermax_norm
  import softermax_fmt_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  input  logic  start,
  input  pow2_t pow,
  input  sum_t  sum,
  output logic  done,
  output prob_t quot
);

  logic        busy;
  logic [2:0]  bit_cnt;
  logic [16:0] rem;
  logic [16:0] divisor;
  logic [16:0] rem_sub;
  logic        q_bit;

  assign divisor = {1'b0, sum};
  assign q_bit   = rem >= divisor;
  assign rem_sub = q_bit ? rem - divisor : rem;  // Restore by keeping rem

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy    <= 1'b0;
      bit_cnt <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy    <= 1'b1;
        bit_cnt <= '0;
      end else if (busy) begin
        bit_cnt <= bit_cnt + 3'd1;
        if (bit_cnt == 3'(PROB_FRAC)) begin  // Last fraction bit
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // First bit is the integer part, which is set only when pow equals sum
  always_ff @(posedge clk) begin
    if (start) begin
      rem <= 17'(pow);
    end else if (busy) begin
      rem  <= {rem_sub[15:0], 1'b0};
      quot <= {quot[6:0], q_bit};
    end
  end

endmodule

//--- logic/softermax_ctrl.sv
// Controller FSM that sequences the fill and drain passes and drives both stream handshakes
`timescale 1ns/1ns
module softermax_ctrl
  import softermax_ctrl_pkg::*;
(
  input  logic   clk,
  input  logic   arst_n,
  input  depth_t depth,
  input  logic   in_valid,
  input  logic   out_ready,
  input  logic   div_done,
  output logic   in_ready,
  output logic   out_valid,
  output logic   win_clear,
  output logic   win_update,
  output logic   buf_we,
  output idx_t   buf_waddr,
  output idx_t   buf_raddr,
  output logic   div_start
);

  ctrl_state_t state;
  ctrl_state_t state_nx;
  depth_t      depth_q;
  idx_t        fill_cnt;
  idx_t        drain_cnt;
  idx_t        last_idx;
  logic        accept;
  logic        drain_last;

  assign accept     = in_valid && in_ready;
  // Depth port is live only on the first beat
  assign last_idx   = (state == IDLE) ? idx_t'(depth - 5'd1) : idx_t'(depth_q - 5'd1);
  assign drain_last = drain_cnt == last_idx;

  assign win_clear  = accept && (state == IDLE);  // First term of a new vector
  assign win_update = accept;
  assign buf_we     = accept;
  assign buf_waddr  = fill_cnt;
  assign buf_raddr  = drain_cnt;
  assign out_valid  = state == HOLD;

  always_comb begin
    state_nx = state;
    unique case (state)
      IDLE, FILL: begin
        if (accept) state_nx = (fill_cnt == last_idx) ? DRAIN : FILL;
      end
      DRAIN:   state_nx = DIVIDE;  // Buffer read lands on this edge
      DIVIDE:  if (div_done) state_nx = HOLD;
      HOLD:    if (out_ready) state_nx = drain_last ? IDLE : DRAIN;
      default: state_nx = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= IDLE;
      in_ready  <= 1'b0;
      div_start <= 1'b0;
      depth_q   <= '0;
      fill_cnt  <= '0;
      drain_cnt <= '0;
    end else begin
      state     <= state_nx;
      in_ready  <= (state_nx == IDLE) || (state_nx == FILL);
      div_start <= state == DRAIN;  // Pulse in the first DIVIDE cycle
      if (win_clear) depth_q <= depth;
      if (accept) fill_cnt <= (fill_cnt == last_idx) ? '0 : fill_cnt + 4'd1;
      if (out_valid && out_ready) drain_cnt <= drain_last ? '0 : drain_cnt + 4'd1;
    end
  end

endmodule

//--- logic/softermax_top.sv
// Softermax top level joining the controller, window, score buffer, drain power and divider
`timescale 1ns/1ns
module softermax_top
  import softermax_fmt_pkg::*;
  import softermax_ctrl_pkg::*;
(
  input  logic   clk,
  input  logic   arst_n,
  input  depth_t depth,
  input  score_t in_data,
  input  logic   in_valid,
  output logic   in_ready,
  output prob_t  out_data,
  output logic   out_valid,
  input  logic   out_ready
);

  logic              win_clear;
  logic              win_update;
  logic              buf_we;
  idx_t              buf_waddr;
  idx_t              buf_raddr;
  logic              div_start;
  logic              div_done;
  exp_int_t          max_int;
  sum_t              sum;
  score_t            buf_rdata;
  logic signed [8:0] drain_diff;
  pow2_t             drain_pow;

  softermax_ctrl u_ctrl (
    .clk, .arst_n, .depth, .in_valid, .out_ready, .div_done,
    .in_ready, .out_valid, .win_clear, .win_update,
    .buf_we, .buf_waddr, .buf_raddr, .div_start
  );

  softermax_window u_window (
    .clk, .arst_n, .clear(win_clear), .update(win_update),
    .score(in_data), .max_int, .sum
  );

  softermax_buffer u_buffer (
    .clk, .we(buf_we), .waddr(buf_waddr), .wdata(in_data),
    .raddr(buf_raddr), .rdata(buf_rdata)
  );

  // Stored score against the final maximum
  assign drain_diff = 9'(buf_rdata) - (9'(max_int) <<< SCORE_FRAC);

  softermax_pow2 u_drain_pow2 (.diff(drain_diff), .pow(drain_pow));

  softermax_norm u_norm (
    .clk, .arst_n, .start(div_start), .pow(drain_pow), .sum,
    .done(div_done), .quot(out_data)
  );

endmodule

//--- bench/softermax_props.sv
// Handshake and reset assertions for softermax_top, attached to the design by bind
`timescale 1ns/1ns
module softermax_props
  import softermax_fmt_pkg::*;
(
  input logic  clk,
  input logic  arst_n,
  input logic  in_ready,
  input logic  out_valid,
  input logic  out_ready,
  input prob_t out_data
);

  // Both streams quiet while reset is held
  a_reset_idle: assert property (@(posedge clk) !arst_n |-> !in_ready && !out_valid)
    else $error("in_ready or out_valid high during reset");

  a_valid_hold: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid)
    else $error("out_valid dropped before out_ready");

  a_data_stable: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && !out_ready |=> $stable(out_data))
    else $error("out_data changed while stalled");

  a_no_overlap: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid |-> !in_ready)
    else $error("in_ready high while a result is offered");

  a_prob_range: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid |-> out_data <= 8'd128)  // Q1.7 never above one
    else $error("out_data above 128");

endmodule

bind softermax_top softermax_props u_props (
  .clk(clk), .arst_n(arst_n), .in_ready(in_ready),
  .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data)
);

//--- bench/softermax_tb.sv
// Testbench for softermax_top that replays the vector trace with random stalls and back-pressure
`timescale 1ns/1ns
module softermax_tb;

  localparam int CLK_PERIOD = 40;
  localparam int REC_WORDS  = 33;  // Depth, 16 scores, 16 expected outputs
  localparam int MEM_WORDS  = 1024;
  localparam int MAX_RECS   = MEM_WORDS / REC_WORDS;

  logic       clk = 1'b0;
  logic       arst_n;
  logic [4:0] depth;
  logic [7:0] in_data;
  logic       in_valid;
  logic       in_ready;
  logic [7:0] out_data;
  logic       out_valid;
  logic       out_ready;

  logic [7:0] trace_mem [MEM_WORDS];
  int         seed = 40;
  int         errors = 0;
  int         vec_errors = 0;
  int         vec_pass = 0;
  int         num_vecs = 0;
  int         cycles = 0;
  int         cycle_limit = 0;

  softermax_top u_softermax_top (
    .clk, .arst_n, .depth, .in_data, .in_valid, .in_ready,
    .out_data, .out_valid, .out_ready
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, the DUT stopped completing handshakes", cycles);
      $display("tests failed");
      $finish;
    end
  end

  // Outputs only move on the rising edge, so the falling edge sees the next handshake
  task automatic run_vector(input int vec);
    int          base;
    int          vec_depth;
    int          sent;
    int          got;
    logic [31:0] rnd;
    logic        offer;
    logic        take;
    base       = vec * REC_WORDS;
    vec_depth  = int'(trace_mem[10'(base)]);
    sent       = 0;
    got        = 0;
    vec_errors = 0;
    depth      = 5'(vec_depth);
    while (got < vec_depth) begin
      @(negedge clk);
      if (sent > 0) depth = 5'd1;  // Must be ignored after the first beat
      if (sent < vec_depth && out_valid) begin
        $display("out_valid rose in vector %0d before all scores were accepted", vec);
        vec_errors++;
      end
      if (sent == vec_depth && in_ready) begin
        $display("in_ready was high in vector %0d while the vector was draining", vec);
        vec_errors++;
      end
      rnd       = $random(seed);
      take      = rnd[0] | rnd[1];
      offer     = (sent < vec_depth) ? (rnd[2] | rnd[3]) : rnd[2];
      out_ready = take;
      if (out_valid && take) begin
        if (out_data != trace_mem[10'(base + 17 + got)]) begin
          $display("[FAIL] out_data vector %0d element %0d expected %h actual %h",
                   vec, got, trace_mem[10'(base + 17 + got)], out_data);
          vec_errors++;
        end
        got++;
      end
      in_valid = offer;
      in_data  = (sent < vec_depth) ? trace_mem[10'(base + 1 + sent)] : 8'h7f;  // Junk in drain
      if (offer && in_ready && sent < vec_depth) sent++;
    end
    // Last transfer sends the FSM back to idle with no extra result
    @(negedge clk);
    in_valid = 1'b0;
    if (!in_ready || out_valid) begin
      $display("vector %0d did not return to idle after its last output", vec);
      vec_errors++;
    end
    if (vec_errors == 0) begin
      vec_pass++;
      $display("vector %0d depth %0d: ok", vec, vec_depth);
    end else begin
      $display("vector %0d depth %0d: %0d errors", vec, vec_depth, vec_errors);
    end
    errors += vec_errors;
  endtask

  initial begin
    arst_n    = 1'b0;
    depth     = 5'd0;
    in_data   = 8'h00;
    in_valid  = 1'b0;
    out_ready = 1'b0;
    $readmemh("bench/softermax_trace.txt", trace_mem);
    while (num_vecs < MAX_RECS && trace_mem[10'(num_vecs * REC_WORDS)] != 8'h00) num_vecs++;
    cycle_limit = num_vecs * (16 + 16 * 14) * 2 + 8;
    repeat (3) begin
      @(negedge clk);
      if (in_ready || out_valid) begin
        $display("in_ready or out_valid was high while reset was held");
        errors++;
      end
    end
    arst_n = 1'b1;
    @(negedge clk);
    if (!in_ready || out_valid) begin
      $display("after reset in_ready did not rise or out_valid was not low");
      errors++;
    end
    if (num_vecs == 0) begin
      $display("the trace holds no vectors");
      errors++;
    end
    for (int v = 0; v < num_vecs; v++) run_vector(v);
    $display("%0d of %0d vectors passed, %0d errors in total", vec_pass, num_vecs, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- bench/softermax_trace.txt
// Per vector two lines: depth then 16 scores, then 16 expected outputs, all hex
// Unused slots are 00 and a depth of 00 ends the trace
04 10 10 10 10 00 00 00 00 00 00 00 00 00 00 00 00
20 20 20 20 00 00 00 00 00 00 00 00 00 00 00 00
06 00 18 25 3F 20 12 00 00 00 00 00 00 00 00 00 00
04 0B 15 40 10 09 00 00 00 00 00 00 00 00 00 00
01 D7 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
80 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
10 05 11 F8 23 20 1C 0A E0 26 30 2F 14 02 35 FF 28
02 04 01 09 08 07 03 00 0B 11 10 05 02 15 02 0C
04 70 80 DF 6A 00 00 00 00 00 00 00 00 00 00 00 00
48 00 00 37 00 00 00 00 00 00 00 00 00 00 00 00
03 10 F0 00 00 00 00 00 00 00 00 00 00 00 00 00 00
49 12 24 00 00 00 00 00 00 00 00 00 00 00 00 00
02 35 35 00 00 00 00 00 00 00 00 00 00 00 00 00 00
40 40 00 00 00 00 00 00 00 00 00 00 00 00 00 00
10 A0 A0 A0 A0 A0 A0 A0 A0 A0 A0 A0 A0 A0 A0 A0 A0
08 08 08 08 08 08 08 08 08 08 08 08 08 08 08 08
05 4C 3C 2C 1C 0C 00 00 00 00 00 00 00 00 00 00 00
42 21 10 08 04 00 00 00 00 00 00 00 00 00 00 00
00

//--- verilog.f
logic/softermax_fmt_pkg.sv
logic/softermax_ctrl_pkg.sv
logic/softermax_pow2.sv
logic/softermax_window.sv
logic/softermax_buffer.sv
logic/softermax_norm.sv
logic/softermax_ctrl.sv
logic/softermax_top.sv
bench/softermax_props.sv
bench/softermax_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the softermax testbench with Verilator and runs it from the project root
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module softermax_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vsoftermax_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
